//--- include/commit_settings.svh
`ifndef COMMIT_SETTINGS_SVH
`define COMMIT_SETTINGS_SVH

// datapath widths
`define COMMIT_XLEN    32
`define COMMIT_AOP_W   8
`define COMMIT_EXCP_W  16

// general exception entry
`define COMMIT_EENTRY  32'h1c00_8000

// aluop codes of the special ops seen at commit
`define COMMIT_OP_ERTN     8'h6a
`define COMMIT_OP_SYSCALL  8'h6b
`define COMMIT_OP_BREAK    8'h6c
`define COMMIT_OP_IDLE     8'h6d
`define COMMIT_OP_CSRRD    8'h70
`define COMMIT_OP_CSRWR    8'h71
`define COMMIT_OP_CSRXCHG  8'h72
// tlbsrch, tlbrd, tlbwr, tlbfill and invtlb all share one code here
`define COMMIT_OP_TLBOP    8'h74
`define COMMIT_OP_CACOP    8'h78

`endif

//--- src/commit_pkg.sv
`include "commit_settings.svh"

package commit_pkg;

    // exception codes, LoongArch numbering
    typedef enum logic [5:0] {
        ECODE_INT  = 6'h00,
        ECODE_PIL  = 6'h01,
        ECODE_PIS  = 6'h02,
        ECODE_PIF  = 6'h03,
        ECODE_PME  = 6'h04,
        ECODE_PPI  = 6'h07,
        // ADEF and ADEM, told apart by esubcode
        ECODE_ADE  = 6'h08,
        ECODE_ALE  = 6'h09,
        ECODE_SYS  = 6'h0b,
        ECODE_BRK  = 6'h0c,
        ECODE_INE  = 6'h0d,
        ECODE_IPE  = 6'h0e,
        ECODE_TLBR = 6'h3f
    } ecode_e;

    localparam logic [8:0] ESUBCODE_ADEF = 9'd0;
    localparam logic [8:0] ESUBCODE_ADEM = 9'd1;

    // register file write request
    typedef struct packed {
        logic       we;
        logic [4:0] waddr;
        logic [`COMMIT_XLEN-1:0] wdata;
    } reg_wr_t;

    // one writeback lane from the memory stage
    typedef struct packed {
        logic                     valid;
        logic [`COMMIT_XLEN-1:0]  pc;
        logic [`COMMIT_AOP_W-1:0] aluop;
        reg_wr_t                  reg_wr;
        logic [`COMMIT_EXCP_W-1:0] excp_num;
        logic [`COMMIT_XLEN-1:0]  mem_addr;
    } wb_lane_t;

    typedef struct packed {
        wb_lane_t lane0;
        wb_lane_t lane1;
    } wb_pair_t;

    // trap record handed to the CSR file
    typedef struct packed {
        logic [`COMMIT_XLEN-1:0] era;
        ecode_e                  ecode;
        logic [8:0]              esubcode;
        logic                    va_error;
        logic [`COMMIT_XLEN-1:0] badv;
        logic                    tlb_refill;
        logic                    tlb_excp;
        logic [18:0]             vppn;
    } trap_t;

    // front-end redirect
    typedef struct packed {
        logic                    valid;
        logic [`COMMIT_XLEN-1:0] target;
    } redirect_t;

endpackage

//--- src/pipe_reg.sv
`timescale 1ns/1ps

module pipe_reg #(
    parameter type payload_t = logic
) (
    input  logic     clk,
    input  logic     rst,
    input  logic     flush_i,
    input  payload_t d_i,
    output payload_t q_o
);

    payload_t q;

    // a flushed stage holds a bubble
    always_ff @(posedge clk) begin
        if (rst || flush_i) begin
            q <= '0;
        end else begin
            q <= d_i;
        end
    end

    assign q_o = q;

    // nothing from a flushed cycle survives into the stage
    a_flush_clears: assert property (
        @(posedge clk) disable iff (rst)
        flush_i |=> (q_o == '0)
    );

endmodule

//--- src/excp_encode.sv
`timescale 1ns/1ps

module excp_encode import commit_pkg::*; (
    input  wb_pair_t pair_i,
    output logic     excp_o,
    output trap_t    trap_o
);

    logic     lane0_excp;
    logic     lane1_excp;
    wb_lane_t rep;

    assign lane0_excp = pair_i.lane0.valid && (|pair_i.lane0.excp_num);
    assign lane1_excp = pair_i.lane1.valid && (|pair_i.lane1.excp_num);

    // lane 0 has priority
    assign rep    = lane0_excp ? pair_i.lane0 : pair_i.lane1;
    assign excp_o = lane0_excp || lane1_excp;

    always_comb begin
        logic [3:0]  idx;
        ecode_e      ecode;
        logic [8:0]  subcode;
        logic        from_pc;
        logic        from_mem;
        logic        refill;
        logic        tlb;
        logic [31:0] addr;

        // lowest set bit wins, so scan downwards
        idx = 4'd0;
        for (int i = 15; i >= 0; i--) begin
            if (rep.excp_num[i]) begin
                idx = 4'(i);
            end
        end

        ecode    = ECODE_INT;
        subcode  = ESUBCODE_ADEF;
        from_pc  = 1'b0;
        from_mem = 1'b0;
        refill   = 1'b0;
        tlb      = 1'b0;
        case (idx)
            4'd1: begin ecode = ECODE_ADE;  from_pc = 1'b1; end
            4'd2: begin ecode = ECODE_TLBR; from_pc = 1'b1; refill = 1'b1; tlb = 1'b1; end
            4'd3: begin ecode = ECODE_PIF;  from_pc = 1'b1; tlb = 1'b1; end
            4'd4: begin ecode = ECODE_PPI;  from_pc = 1'b1; tlb = 1'b1; end
            4'd5: ecode = ECODE_SYS;
            4'd6: ecode = ECODE_BRK;
            4'd7: ecode = ECODE_INE;
            4'd8: ecode = ECODE_IPE;
            4'd9: begin ecode = ECODE_ALE;  from_mem = 1'b1; end
            4'd10: begin
                ecode    = ECODE_ADE;
                subcode  = ESUBCODE_ADEM;
                from_mem = 1'b1;
            end
            4'd11: begin ecode = ECODE_TLBR; from_mem = 1'b1; refill = 1'b1; tlb = 1'b1; end
            4'd12: begin ecode = ECODE_PME;  from_mem = 1'b1; tlb = 1'b1; end
            4'd13: begin ecode = ECODE_PPI;  from_mem = 1'b1; tlb = 1'b1; end
            4'd14: begin ecode = ECODE_PIS;  from_mem = 1'b1; tlb = 1'b1; end
            4'd15: begin ecode = ECODE_PIL;  from_mem = 1'b1; tlb = 1'b1; end
            default: ecode = ECODE_INT;
        endcase

        // fetch faults report the pc, data faults the access address
        addr = from_pc ? rep.pc : (from_mem ? rep.mem_addr : '0);

        trap_o = '0;
        if (excp_o) begin
            trap_o.era        = rep.pc;
            trap_o.ecode      = ecode;
            trap_o.esubcode   = subcode;
            trap_o.va_error   = from_pc || from_mem;
            trap_o.badv       = addr;
            trap_o.tlb_refill = refill;
            trap_o.tlb_excp   = tlb;
            trap_o.vppn       = addr[31:13];
        end
    end

endmodule

//--- src/commit_ctrl.sv
`timescale 1ns/1ps
`include "commit_settings.svh"

module commit_ctrl import commit_pkg::*; (
    input  logic       clk,
    input  logic       rst,

    input  wb_pair_t   pair_i,
    input  logic       excp_i,
    input  logic       branch0_i,

    input  logic [1:0] ex_stallreq_i,
    input  logic [1:0] mem_stallreq_i,
    input  logic       dispatch_stallreq_i,
    input  logic       pri_issue_i,

    output reg_wr_t    reg_wr0_o,
    output reg_wr_t    reg_wr1_o,
    output logic       flush_o,
    output logic [1:0] ex_mem_flush_o,
    output logic       ertn_o,
    output logic [4:0] stall_o,
    output logic       pri_stall_o
);

    wb_lane_t lane0;
    wb_lane_t lane1;
    logic [`COMMIT_AOP_W-1:0] op0;

    logic lane0_excp;
    logic lane1_excp;
    logic lane0_ends_group;
    logic lane0_pri;
    logic pri_stall_q;

    assign lane0 = pair_i.lane0;
    assign lane1 = pair_i.lane1;
    assign op0   = lane0.aluop;

    assign lane0_excp = lane0.valid && (|lane0.excp_num);
    assign lane1_excp = lane1.valid && (|lane1.excp_num);

    // ops after which lane 1 must not retire
    assign lane0_ends_group = lane0.valid &&
                              (op0 == `COMMIT_OP_ERTN  || op0 == `COMMIT_OP_SYSCALL ||
                               op0 == `COMMIT_OP_BREAK || op0 == `COMMIT_OP_IDLE);

    // privileged ops only issue alone, so they retire in lane 0
    assign lane0_pri = lane0.valid &&
                       (op0 == `COMMIT_OP_CSRRD   || op0 == `COMMIT_OP_CSRWR   ||
                        op0 == `COMMIT_OP_CSRXCHG || op0 == `COMMIT_OP_SYSCALL ||
                        op0 == `COMMIT_OP_BREAK   || op0 == `COMMIT_OP_ERTN    ||
                        op0 == `COMMIT_OP_IDLE    || op0 == `COMMIT_OP_TLBOP   ||
                        op0 == `COMMIT_OP_CACOP);

    // register file write ports
    assign reg_wr0_o = (lane0.valid && !lane0_excp) ? lane0.reg_wr : '0;
    assign reg_wr1_o = (lane1.valid && !lane1_excp && !excp_i && !lane0_ends_group) ?
                       lane1.reg_wr : '0;

    // flushes
    assign ertn_o = (lane0.valid && lane0.aluop == `COMMIT_OP_ERTN) ||
                    (lane1.valid && lane1.aluop == `COMMIT_OP_ERTN);
    assign flush_o = excp_i || ertn_o;

    // lane 1 is also squashed behind a taken branch in lane 0
    assign ex_mem_flush_o[0] = flush_o;
    assign ex_mem_flush_o[1] = flush_o || branch0_i;

    // stall arbitration, later stages first
    always_comb begin
        if ((|ex_stallreq_i) || (|mem_stallreq_i)) begin
            stall_o = 5'b11110;
        end else if (dispatch_stallreq_i) begin
            stall_o = 5'b11100;
        end else begin
            stall_o = 5'b00000;
        end
    end

    // privileged issue barrier
    always_ff @(posedge clk) begin
        if (rst) begin
            pri_stall_q <= 1'b0;
        end else if (pri_issue_i) begin
            // a new issue wins over a commit in the same cycle
            pri_stall_q <= 1'b1;
        end else if (lane0_pri || excp_i) begin
            pri_stall_q <= 1'b0;
        end
    end

    assign pri_stall_o = pri_stall_q;

    // lane 1 retires only behind a clean lane 0
    a_no_wr1_behind_excp: assert property (
        @(posedge clk) disable iff (rst)
        lane0_excp |-> !reg_wr1_o.we
    );

endmodule

//--- src/trap_csr.sv
`timescale 1ns/1ps
`include "commit_settings.svh"

module trap_csr import commit_pkg::*; (
    input  logic      clk,
    input  logic      rst,
    input  logic      excp_i,
    input  logic      ertn_i,
    input  trap_t     trap_i,
    output trap_t     trap_o,
    output redirect_t redirect_o
);

    trap_t     trap_q;
    redirect_t redir_q;

    // trap record held until the next exception
    always_ff @(posedge clk) begin
        if (rst) begin
            trap_q <= '0;
        end else if (excp_i) begin
            trap_q <= trap_i;
        end
    end

    // exception entry beats the return address
    always_ff @(posedge clk) begin
        if (rst) begin
            redir_q <= '0;
        end else begin
            redir_q.valid <= excp_i || ertn_i;
            if (excp_i) begin
                redir_q.target <= `COMMIT_EENTRY;
            end else if (ertn_i) begin
                redir_q.target <= trap_q.era;
            end else begin
                redir_q.target <= '0;
            end
        end
    end

    assign trap_o     = trap_q;
    assign redirect_o = redir_q;

    // the group behind a redirect is flushed, so redirects never come back to back
    a_no_back_to_back: assert property (
        @(posedge clk) disable iff (rst)
        (excp_i || ertn_i) |=> !(excp_i || ertn_i)
    );

endmodule

//--- src/commit_top.sv
`timescale 1ns/1ps

module commit_top import commit_pkg::*; (
    input  logic       clk,
    input  logic       rst,

    input  wb_lane_t   lane0_i,
    input  wb_lane_t   lane1_i,

    input  logic [1:0] ex_stallreq_i,
    input  logic [1:0] mem_stallreq_i,
    input  logic       dispatch_stallreq_i,
    input  logic       pri_issue_i,
    input  logic       branch0_i,

    output reg_wr_t    reg_wr0_o,
    output reg_wr_t    reg_wr1_o,
    output logic       flush_o,
    output logic [1:0] ex_mem_flush_o,
    output logic [4:0] stall_o,
    output logic       pri_stall_o,
    output trap_t      trap_o,
    output redirect_t  redirect_o
);

    wb_pair_t  pair_in;
    wb_pair_t  pair_q;
    logic      excp;
    logic      ertn;
    logic      flush;
    trap_t     trap_enc;
    redirect_t redirect_pre;

    assign pair_in.lane0 = lane0_i;
    assign pair_in.lane1 = lane1_i;

    // latch stage, dropped behind a flush
    pipe_reg #(.payload_t(wb_pair_t)) u_lane_stage (
        .clk     (clk),
        .rst     (rst),
        .flush_i (flush),
        .d_i     (pair_in),
        .q_o     (pair_q)
    );

    excp_encode u_excp_encode (
        .pair_i (pair_q),
        .excp_o (excp),
        .trap_o (trap_enc)
    );

    commit_ctrl u_commit_ctrl (
        .clk                 (clk),
        .rst                 (rst),
        .pair_i              (pair_q),
        .excp_i              (excp),
        .branch0_i           (branch0_i),
        .ex_stallreq_i       (ex_stallreq_i),
        .mem_stallreq_i      (mem_stallreq_i),
        .dispatch_stallreq_i (dispatch_stallreq_i),
        .pri_issue_i         (pri_issue_i),
        .reg_wr0_o           (reg_wr0_o),
        .reg_wr1_o           (reg_wr1_o),
        .flush_o             (flush),
        .ex_mem_flush_o      (ex_mem_flush_o),
        .ertn_o              (ertn),
        .stall_o             (stall_o),
        .pri_stall_o         (pri_stall_o)
    );

    trap_csr u_trap_csr (
        .clk        (clk),
        .rst        (rst),
        .excp_i     (excp),
        .ertn_i     (ertn),
        .trap_i     (trap_enc),
        .trap_o     (trap_o),
        .redirect_o (redirect_pre)
    );

    // second register on the way to fetch
    pipe_reg #(.payload_t(redirect_t)) u_redirect_stage (
        .clk     (clk),
        .rst     (rst),
        .flush_i (1'b0),
        .d_i     (redirect_pre),
        .q_o     (redirect_o)
    );

    assign flush_o = flush;

endmodule

//--- testbench/tb_commit_props.svh
`ifndef TB_COMMIT_PROPS_SVH
`define TB_COMMIT_PROPS_SVH

// write ports one cycle after the lanes arrive
chk_wr0: assert property (@(posedge clk) disable iff (rst) reg_wr0_o == exp_wr0)
    else report_mismatch("retire_lane0", $sampled(exp_wr0), $sampled(reg_wr0_o));
chk_wr1: assert property (@(posedge clk) disable iff (rst) reg_wr1_o == exp_wr1)
    else report_mismatch("retire_lane1", $sampled(exp_wr1), $sampled(reg_wr1_o));

// group behind a flush is a bubble
chk_bubble: assert property (@(posedge clk) disable iff (rst)
    flush_o |=> !(reg_wr0_o.we || reg_wr1_o.we))
    else report_mismatch("flush_bubble", 2'b00, {$sampled(reg_wr0_o.we), $sampled(reg_wr1_o.we)});

chk_flush: assert property (@(posedge clk) disable iff (rst) flush_o == exp_flush)
    else report_mismatch("flush", $sampled(exp_flush), $sampled(flush_o));
chk_ex_mem_flush: assert property (@(posedge clk) disable iff (rst)
    ex_mem_flush_o == exp_ex_mem_flush)
    else report_mismatch("ex_mem_flush", $sampled(exp_ex_mem_flush), $sampled(ex_mem_flush_o));

// same-cycle stall arbitration
chk_stall: assert property (@(posedge clk) disable iff (rst) stall_o == exp_stall)
    else report_mismatch("stall", $sampled(exp_stall), $sampled(stall_o));

// trap record from N+2
chk_trap: assert property (@(posedge clk) disable iff (rst) trap_o == model_trap)
    else report_mismatch("trap_record", $sampled(model_trap), $sampled(trap_o));

// redirect at N+3, single cycle
chk_redir_valid: assert property (@(posedge clk) disable iff (rst)
    redirect_o.valid == redir_b.valid)
    else report_mismatch("redirect_valid", $sampled(redir_b.valid), $sampled(redirect_o.valid));
chk_redir_target: assert property (@(posedge clk) disable iff (rst)
    redirect_o.valid |-> (redirect_o.target == redir_b.target))
    else report_mismatch("redirect_target", $sampled(redir_b.target), $sampled(redirect_o.target));
chk_redir_pulse: assert property (@(posedge clk) disable iff (rst)
    redirect_o.valid |=> !redirect_o.valid)
    else report_mismatch("redirect_pulse", 1'b0, $sampled(redirect_o.valid));

chk_pri_stall: assert property (@(posedge clk) disable iff (rst) pri_stall_o == model_pri)
    else report_mismatch("pri_stall", $sampled(model_pri), $sampled(pri_stall_o));

`endif

//--- testbench/tb_commit_top.sv
`timescale 1ns/1ps
`include "commit_settings.svh"

module tb_commit_top import commit_pkg::*; ();

    localparam int reset_cycles   = 8;
    localparam int stim_cycles    = 2000;
    localparam int timeout_cycles = stim_cycles + 1000;

    // exception bit to code, plus where each bit takes its address from
    localparam ecode_e code_by_bit [16] = '{
        ECODE_INT, ECODE_ADE, ECODE_TLBR, ECODE_PIF, ECODE_PPI, ECODE_SYS, ECODE_BRK,
        ECODE_INE, ECODE_IPE, ECODE_ALE, ECODE_ADE, ECODE_TLBR, ECODE_PME, ECODE_PPI,
        ECODE_PIS, ECODE_PIL
    };
    localparam logic [15:0] pc_src_mask  = 16'h001e;
    localparam logic [15:0] mem_src_mask = 16'hfe00;
    localparam logic [15:0] refill_mask  = 16'h0804;
    localparam logic [15:0] tlb_mask     = 16'hf81c;

    localparam logic [7:0] special_ops [9] = '{
        `COMMIT_OP_ERTN, `COMMIT_OP_SYSCALL, `COMMIT_OP_BREAK, `COMMIT_OP_IDLE,
        `COMMIT_OP_CSRRD, `COMMIT_OP_CSRWR, `COMMIT_OP_CSRXCHG, `COMMIT_OP_TLBOP,
        `COMMIT_OP_CACOP
    };

    logic       clk;
    logic       rst;
    wb_lane_t   lane0_i;
    wb_lane_t   lane1_i;
    logic [1:0] ex_stallreq_i;
    logic [1:0] mem_stallreq_i;
    logic       dispatch_stallreq_i;
    logic       pri_issue_i;
    logic       branch0_i;
    reg_wr_t    reg_wr0_o;
    reg_wr_t    reg_wr1_o;
    logic       flush_o;
    logic [1:0] ex_mem_flush_o;
    logic [4:0] stall_o;
    logic       pri_stall_o;
    trap_t      trap_o;
    redirect_t  redirect_o;

    logic [31:0] lfsr = 32'h7335_81a5;
    int          cycle_count;

    // reference state
    wb_pair_t   model_pair;
    trap_t      model_trap;
    redirect_t  redir_a;
    redirect_t  redir_b;
    logic       model_pri;
    logic       exp_excp;
    logic       exp_ertn;
    logic       exp_flush;
    logic       pri_clear;
    logic [1:0] exp_ex_mem_flush;
    logic [4:0] exp_stall;
    reg_wr_t    exp_wr0;
    reg_wr_t    exp_wr1;
    trap_t      exp_trap;

    commit_top u_commit_top (.*);

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    function automatic logic [31:0] take_bits(input int n);
        logic [31:0] r;
        logic        fb;
        r = '0;
        for (int i = 0; i < n; i++) begin
            fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
            lfsr = {lfsr[30:0], fb};
            r    = {r[30:0], fb};
        end
        return r;
    endfunction

    function automatic logic lane_has_excp(input wb_lane_t l);
        return l.valid && (l.excp_num != '0);
    endfunction

    function automatic logic lane_ends_group(input wb_lane_t l);
        return l.valid && (l.aluop inside {`COMMIT_OP_ERTN, `COMMIT_OP_SYSCALL,
                                           `COMMIT_OP_BREAK, `COMMIT_OP_IDLE});
    endfunction

    function automatic trap_t expected_trap(input wb_pair_t p);
        trap_t    t;
        wb_lane_t rep;
        int       b;
        t = '0;
        if (!lane_has_excp(p.lane0) && !lane_has_excp(p.lane1)) begin
            return t;
        end
        rep = lane_has_excp(p.lane0) ? p.lane0 : p.lane1;
        b = 0;
        while (!rep.excp_num[b]) begin
            b++;
        end
        t.era        = rep.pc;
        t.ecode      = code_by_bit[b];
        t.esubcode   = (b == 10) ? 9'd1 : 9'd0;
        t.va_error   = pc_src_mask[b] || mem_src_mask[b];
        t.badv       = pc_src_mask[b] ? rep.pc : (mem_src_mask[b] ? rep.mem_addr : '0);
        t.tlb_refill = refill_mask[b];
        t.tlb_excp   = tlb_mask[b];
        t.vppn       = t.badv[31:13];
        return t;
    endfunction

    // about one lane in four faults and half the valid lanes carry a special op
    function automatic wb_lane_t random_lane();
        wb_lane_t   l;
        logic [3:0] sel;
        l = '0;
        if (take_bits(2) == 0) begin
            return l;
        end
        l.valid  = 1'b1;
        l.pc     = take_bits(32);
        l.mem_addr = take_bits(32);
        l.reg_wr.we    = 1'(take_bits(1));
        l.reg_wr.waddr = 5'(take_bits(5));
        l.reg_wr.wdata = take_bits(32);
        sel      = 4'(take_bits(4));
        l.aluop  = (sel < 9) ? special_ops[sel] : 8'(take_bits(8));
        case (take_bits(3))
            0: l.excp_num = 16'h1 << take_bits(4);
            1: l.excp_num = 16'(take_bits(16));
            default: l.excp_num = '0;
        endcase
        return l;
    endfunction

    assign exp_excp  = lane_has_excp(model_pair.lane0) || lane_has_excp(model_pair.lane1);
    assign exp_ertn  = (model_pair.lane0.valid && model_pair.lane0.aluop == `COMMIT_OP_ERTN) ||
                       (model_pair.lane1.valid && model_pair.lane1.aluop == `COMMIT_OP_ERTN);
    assign exp_flush = exp_excp || exp_ertn;
    assign exp_ex_mem_flush = {exp_flush || branch0_i, exp_flush};
    assign exp_trap  = expected_trap(model_pair);
    assign exp_wr0   = (model_pair.lane0.valid && !lane_has_excp(model_pair.lane0)) ?
                       model_pair.lane0.reg_wr : '0;
    assign exp_wr1   = (model_pair.lane1.valid && !exp_excp &&
                        !lane_ends_group(model_pair.lane0)) ? model_pair.lane1.reg_wr : '0;
    assign pri_clear = exp_excp || (model_pair.lane0.valid && (model_pair.lane0.aluop inside {
                           `COMMIT_OP_CSRRD, `COMMIT_OP_CSRWR, `COMMIT_OP_CSRXCHG,
                           `COMMIT_OP_SYSCALL, `COMMIT_OP_BREAK, `COMMIT_OP_ERTN,
                           `COMMIT_OP_IDLE, `COMMIT_OP_TLBOP, `COMMIT_OP_CACOP}));
    assign exp_stall = ((ex_stallreq_i != 2'b00) || (mem_stallreq_i != 2'b00)) ? 5'b11110 :
                       (dispatch_stallreq_i ? 5'b11100 : 5'b00000);

    // latch, trap record, two redirect registers and the barrier
    always @(posedge clk) begin
        if (rst) begin
            model_pair <= '0;
            model_trap <= '0;
            redir_a    <= '0;
            redir_b    <= '0;
            model_pri  <= 1'b0;
        end else begin
            model_pair.lane0 <= exp_flush ? '0 : lane0_i;
            model_pair.lane1 <= exp_flush ? '0 : lane1_i;
            if (exp_excp) begin
                model_trap <= exp_trap;
            end
            redir_a.valid  <= exp_flush;
            redir_a.target <= exp_excp ? `COMMIT_EENTRY : model_trap.era;
            redir_b        <= redir_a;
            if (pri_issue_i) begin
                model_pri <= 1'b1;
            end else if (pri_clear) begin
                model_pri <= 1'b0;
            end
        end
    end

    task automatic abort_run();
        $display("Test failures found");
        $fatal(1);
    endtask

    task automatic report_mismatch(input string test_name, input logic [127:0] exp_val,
                                   input logic [127:0] act_val);
        $display("ERR %s expected %0h actual %0h", test_name, exp_val, act_val);
        abort_run();
    endtask

    task automatic drive_cycle();
        lane0_i             <= random_lane();
        lane1_i             <= random_lane();
        ex_stallreq_i       <= (take_bits(3) == 0) ? 2'(take_bits(2)) : 2'b00;
        mem_stallreq_i      <= (take_bits(3) == 0) ? 2'(take_bits(2)) : 2'b00;
        dispatch_stallreq_i <= (take_bits(3) == 0);
        pri_issue_i         <= (take_bits(3) == 0);
        branch0_i           <= (take_bits(2) == 0);
    endtask

    initial begin
        rst                 = 1'b1;
        lane0_i             = '0;
        lane1_i             = '0;
        ex_stallreq_i       = 2'b00;
        mem_stallreq_i      = 2'b00;
        dispatch_stallreq_i = 1'b0;
        pri_issue_i         = 1'b0;
        branch0_i           = 1'b0;
        repeat (reset_cycles) @(posedge clk);
        rst <= 1'b0;
        for (int i = 0; i < stim_cycles; i++) begin
            @(posedge clk);
            drive_cycle();
        end
        @(posedge clk);
        lane0_i     <= '0;
        lane1_i     <= '0;
        pri_issue_i <= 1'b0;
        // let the last redirect drain out
        repeat (6) @(posedge clk);
        $display("All tests passed!");
        $finish;
    end

    initial begin
        cycle_count = 0;
        while (cycle_count < timeout_cycles) begin
            @(posedge clk);
            cycle_count++;
        end
        $display("run did not finish within %0d cycles", timeout_cycles);
        abort_run();
    end

    `include "tb_commit_props.svh"

endmodule

//--- compile.f
+incdir+include
+incdir+testbench
src/commit_pkg.sv
src/pipe_reg.sv
src/excp_encode.sv
src/commit_ctrl.sv
src/trap_csr.sv
src/commit_top.sv
testbench/tb_commit_top.sv
